//--- bench/exu_tests.svh
// ============================
// Directed tests, included in the testbench module
// ============================
`ifndef EXU_TESTS_SVH
`define EXU_TESTS_SVH

// Sign-extended 12-bit offset ending in the given lane
function automatic logic [31:0] lane_imm(input logic [1:0] lane);
    logic [31:0] r;
    r = rand_word();
    return {{20{r[11]}}, r[11:2], lane};
endfunction

task automatic test_alu_ops();
    int i;
    cur_test = "test_alu_ops";
    grant_credits(20);
    for (i = 0; i < 10; i++) begin
        issue_alu(dec_pkg::alu_op_e'(i), 1'b0, 1'b0, 1'b0,
                  rand_word(), rand_word(), rand_word(), rand_word());
    end
    issue_alu(dec_pkg::SLL, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0000_0001, 32'd31);
    issue_alu(dec_pkg::SRL, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 32'h8000_0000, 32'd31);
    issue_alu(dec_pkg::SRA, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 32'h8000_0000, 32'd31);
    issue_alu(dec_pkg::SLL, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0000_0003, 32'd33); // Wraps to 1
    issue_alu(dec_pkg::SLT, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 32'hffff_ffff, 32'd1);
    issue_alu(dec_pkg::SLTU, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 32'hffff_ffff, 32'd1);
    issue_alu(dec_pkg::SLT, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 32'd1, 32'hffff_ffff);
    issue_alu(dec_pkg::SLTU, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 32'd1, 32'hffff_ffff);
    issue_alu(dec_pkg::ADD, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 32'hffff_ffff, 32'd1);
    issue_alu(dec_pkg::SUB, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 32'd1);
    drain();
endtask

task automatic test_operand_select();
    cur_test = "test_operand_select";
    grant_credits(5);
    // LUI, then AUIPC
    issue_alu(dec_pkg::ADD, 1'b0, 1'b1, 1'b1, 32'h0040_0100, 32'h1234_5000,
              rand_word(), rand_word());
    issue_alu(dec_pkg::ADD, 1'b1, 1'b0, 1'b1, 32'h0040_0100, 32'hffff_f000,
              rand_word(), rand_word());
    issue_alu(dec_pkg::ADD, 1'b0, 1'b0, 1'b1, rand_word(), 32'hffff_fffb,
              rand_word(), rand_word());
    issue_alu(dec_pkg::ADD, 1'b0, 1'b0, 1'b0, rand_word(), rand_word(),
              rand_word(), rand_word());
    issue_alu(dec_pkg::SUB, 1'b1, 1'b0, 1'b0, rand_word(), rand_word(),
              rand_word(), rand_word());
    drain();
endtask

task automatic test_store_lanes();
    int lane;
    cur_test = "test_store_lanes";
    grant_credits(10);
    for (lane = 0; lane < 4; lane++) begin
        issue_mem(1'b1, exu_pkg::SZ_BYTE, 1'b0, rand_word() & 32'hffff_fffc,
                  lane_imm(lane[1:0]), rand_word());
    end
    issue_mem(1'b1, exu_pkg::SZ_HALF, 1'b0, rand_word() & 32'hffff_fffc, lane_imm(2'd0),
              rand_word());
    issue_mem(1'b1, exu_pkg::SZ_HALF, 1'b0, rand_word() & 32'hffff_fffc, lane_imm(2'd2),
              rand_word());
    issue_mem(1'b1, exu_pkg::SZ_WORD, 1'b0, rand_word() & 32'hffff_fffc, lane_imm(2'd0),
              rand_word());
    // Loads carry no mask and no data
    issue_mem(1'b0, exu_pkg::SZ_BYTE, 1'b1, rand_word() & 32'hffff_fffc, lane_imm(2'd3),
              rand_word());
    issue_mem(1'b0, exu_pkg::SZ_HALF, 1'b0, rand_word() & 32'hffff_fffc, lane_imm(2'd2),
              rand_word());
    issue_mem(1'b0, exu_pkg::SZ_WORD, 1'b0, rand_word() & 32'hffff_fffc, lane_imm(2'd0),
              rand_word());
    drain();
endtask

task automatic test_misaligned();
    int st;
    int lane;
    cur_test = "test_misaligned";
    grant_credits(10);
    for (st = 0; st < 2; st++) begin
        for (lane = 1; lane < 4; lane++) begin
            issue_mem(st[0], exu_pkg::SZ_WORD, 1'b0, rand_word() & 32'hffff_fffc,
                      lane_imm(lane[1:0]), rand_word());
        end
        for (lane = 1; lane < 4; lane += 2) begin
            issue_mem(st[0], exu_pkg::SZ_HALF, 1'b0, rand_word() & 32'hffff_fffc,
                      lane_imm(lane[1:0]), rand_word());
        end
    end
    drain();
endtask

task automatic test_credit_backpressure();
    int i;
    int returned_before;
    cur_test = "test_credit_backpressure";
    returned_before = credits_returned;
    for (i = 0; i < FIFO_DEPTH; i++) begin
        issue_alu(dec_pkg::ADD, 1'b0, 1'b0, 1'b0, rand_word(), rand_word(),
                  rand_word(), rand_word());
    end
    check_value("issue credits left", 32'h0, issue_credits);
    repeat (10) begin
        @(negedge clk);
        if (res_valid !== 1'b0 || issue_credit !== 1'b0) begin
            report_error("result or issue credit seen without an output credit");
        end
    end
    // One result per granted credit
    for (i = 0; i < FIFO_DEPTH; i++) begin
        grant_credits(1);
        repeat (3) @(negedge clk);
        check_value("queued results", FIFO_DEPTH - 1 - i, exp_q.size());
    end
    check_value("issue credits returned", FIFO_DEPTH, credits_returned - returned_before);
endtask

task automatic test_latency();
    int i;
    int start_edge;
    int start_count;
    cur_test = "test_latency";
    grant_credits(1);
    issue_alu(dec_pkg::OR, 1'b0, 1'b0, 1'b0, rand_word(), rand_word(),
              rand_word(), rand_word());
    check_value("res_valid edge 1", 32'h0, res_valid);
    @(negedge clk);
    check_value("res_valid edge 2", 32'h0, res_valid);
    @(negedge clk);
    check_value("res_valid edge 3", 32'h1, res_valid);
    drain();
    grant_credits(8);
    start_edge  = edge_cnt;
    start_count = results_seen;
    for (i = 0; i < 8; i++) begin
        issue_alu(dec_pkg::alu_op_e'(i), 1'b0, 1'b0, 1'b0, rand_word(), rand_word(),
                  rand_word(), rand_word());
    end
    drain();
    check_value("burst results", 32'd8, results_seen - start_count);
    check_value("last result edge", start_edge + 10, last_res_edge);  // First at +3
endtask

`endif

//--- bench/exu_tb.sv
// ============================
// Testbench for the execute slice. Credit-tracking issuer,
// in-order result monitor and reference models.
// ============================
`timescale 1ns/100ps

module exu_tb;

    localparam int FIFO_DEPTH      = 4;
    localparam int N_ITEMS         = 54 + FIFO_DEPTH;  // All items the tests issue
    localparam int WATCHDOG_CYCLES = N_ITEMS * 20 + 500;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       issue_valid;
    dec_pkg::grp_e              issue_grp;
    dec_pkg::dec_info_u         issue_info;
    logic [31:0]                issue_pc;
    logic [31:0]                issue_imm;
    logic [31:0]                rs1_rdata;
    logic [31:0]                rs2_rdata;
    logic                       issue_credit;
    logic                       res_credit;
    logic                       res_valid;
    dec_pkg::grp_e              res_grp;
    logic [31:0]                res_data;
    logic [exu_pkg::MASK_W-1:0] res_wmask;
    logic [31:0]                res_wdata;
    logic                       res_store;
    logic                       res_misaligned;

    integer      seed = 32'h6878122e;
    string       cur_test = "reset";
    int          error_count = 0;
    int          check_count = 0;
    int          issue_credits = FIFO_DEPTH;  // Held by the issuer after reset
    int          credits_returned = 0;
    int          results_seen = 0;
    int          edge_cnt = 0;
    int          last_res_edge = 0;
    // {grp, data, wmask, wdata, store, misaligned}
    logic [70:0] exp_q[$];

    exu_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) exu_top_inst (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .issue_valid_i    (issue_valid),
        .issue_grp_i      (issue_grp),
        .issue_info_i     (issue_info),
        .issue_pc_i       (issue_pc),
        .issue_imm_i      (issue_imm),
        .rs1_rdata_i      (rs1_rdata),
        .rs2_rdata_i      (rs2_rdata),
        .issue_credit_o   (issue_credit),
        .res_credit_i     (res_credit),
        .res_valid_o      (res_valid),
        .res_grp_o        (res_grp),
        .res_data_o       (res_data),
        .res_wmask_o      (res_wmask),
        .res_wdata_o      (res_wdata),
        .res_store_o      (res_store),
        .res_misaligned_o (res_misaligned)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH test=%s field=%s expected=%h actual=%h",
                     cur_test, field, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR: %s in %s", msg, cur_test);
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // RV32I integer semantics, shift amount from op2[4:0]
    function automatic logic [31:0] alu_model(input dec_pkg::alu_op_e op,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            dec_pkg::ADD:  return a + b;
            dec_pkg::SUB:  return a - b;
            dec_pkg::SLL:  return a << sh;
            dec_pkg::SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            dec_pkg::SLTU: return {31'b0, a < b};
            dec_pkg::XOR:  return a ^ b;
            dec_pkg::SRL:  return a >> sh;
            dec_pkg::SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            dec_pkg::OR:   return a | b;
            dec_pkg::AND:  return a & b;
            default:       return 32'h0;
        endcase
    endfunction

    // Expected memory entry: lanes by size and address, no write when misaligned
    function automatic logic [70:0] mem_model(input logic is_store, input exu_pkg::size_e size,
                                              input logic [31:0] base, input logic [31:0] imm,
                                              input logic [31:0] sdata);
        logic [31:0] addr;
        logic [1:0]  off;
        logic [3:0]  mask;
        logic [31:0] data;
        logic        mis;
        addr = base + imm;
        off  = addr[1:0];
        mis  = ((size == exu_pkg::SZ_WORD) && (off != 2'b00)) ||
               ((size == exu_pkg::SZ_HALF) && off[0]);
        mask = 4'b0000;
        data = 32'h0;
        if (is_store) begin
            case (size)
                exu_pkg::SZ_BYTE: begin
                    mask = 4'b0001 << off;
                    data = {24'b0, sdata[7:0]} << (8 * off);
                end
                exu_pkg::SZ_HALF: begin
                    mask = off[1] ? 4'b1100 : 4'b0011;
                    data = off[1] ? (sdata << 16) : (sdata & 32'h0000_ffff);
                end
                default: begin
                    mask = 4'b1111;
                    data = sdata;
                end
            endcase
            if (mis) begin
                mask = 4'b0000;
            end
        end
        return {dec_pkg::GRP_MEM, addr, mask, data, is_store, mis};
    endfunction

    task automatic grant_credits(input int n);
        repeat (n) begin
            res_credit = 1'b1;
            @(negedge clk);
        end
        res_credit = 1'b0;
    endtask

    // Spends one issue credit, waits while none is left
    task automatic issue_item(input dec_pkg::grp_e grp, input dec_pkg::dec_info_u info,
                              input logic [31:0] pc, input logic [31:0] imm,
                              input logic [31:0] rs1, input logic [31:0] rs2,
                              input logic [70:0] expected);
        while (issue_credits == 0) begin
            @(negedge clk);
        end
        issue_valid = 1'b1;
        issue_grp   = grp;
        issue_info  = info;
        issue_pc    = pc;
        issue_imm   = imm;
        rs1_rdata   = rs1;
        rs2_rdata   = rs2;
        issue_credits--;
        exp_q.push_back(expected);
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic issue_alu(input dec_pkg::alu_op_e op, input logic op1_pc,
                             input logic op1_zero, input logic op2_imm,
                             input logic [31:0] pc, input logic [31:0] imm,
                             input logic [31:0] rs1, input logic [31:0] rs2);
        dec_pkg::alu_fields_t af;
        dec_pkg::dec_info_u   info;
        logic [31:0]          a;
        logic [31:0]          b;
        af          = '0;
        af.op       = op;
        af.op1_pc   = op1_pc;
        af.op1_zero = op1_zero;
        af.op2_imm  = op2_imm;
        info.alu    = af;
        a = op1_pc ? pc : (op1_zero ? 32'h0 : rs1);
        b = op2_imm ? imm : rs2;
        issue_item(dec_pkg::GRP_ALU, info, pc, imm, rs1, rs2,
                   {dec_pkg::GRP_ALU, alu_model(op, a, b), 4'b0000, 32'h0, 2'b00});
    endtask

    task automatic issue_mem(input logic is_store, input exu_pkg::size_e size,
                             input logic is_unsigned, input logic [31:0] base,
                             input logic [31:0] imm, input logic [31:0] sdata);
        dec_pkg::mem_fields_t mf;
        dec_pkg::dec_info_u   info;
        mf             = '0;
        mf.is_store    = is_store;
        mf.size        = size;
        mf.is_unsigned = is_unsigned;
        info.mem       = mf;
        issue_item(dec_pkg::GRP_MEM, info, rand_word(), imm, base, sdata,
                   mem_model(is_store, size, base, imm, sdata));
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            report_error($sformatf("%0d expected results never arrived", exp_q.size()));
            exp_q.delete();
        end
    endtask

    `include "exu_tests.svh"

    // Compares every delivered result in issue order
    always @(negedge clk) begin : result_monitor
        logic [70:0] expected;
        if (rst_n === 1'b1) begin
            if (issue_credit !== res_valid) begin
                report_error("issue credit and result valid disagree");
            end
            if (res_valid === 1'b1) begin
                results_seen++;
                last_res_edge = edge_cnt;
                if (exp_q.size() == 0) begin
                    report_error("result delivered with nothing outstanding");
                end else begin
                    expected = exp_q.pop_front();
                    check_value("grp", expected[70], res_grp);
                    check_value("data", expected[69:38], res_data);
                    check_value("wmask", expected[37:34], res_wmask);
                    check_value("wdata", expected[33:2], res_wdata);
                    check_value("store", expected[1], res_store);
                    check_value("misaligned", expected[0], res_misaligned);
                end
            end
            if (issue_credit === 1'b1) begin
                issue_credits++;
                credits_returned++;
                if (issue_credits > FIFO_DEPTH) begin
                    report_error("more issue credits returned than were spent");
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog timeout, run not finished after %0d cycles",
                 WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_grp   = dec_pkg::GRP_ALU;
        issue_info  = '0;
        issue_pc    = 32'h0;
        issue_imm   = 32'h0;
        rs1_rdata   = 32'h0;
        rs2_rdata   = 32'h0;
        res_credit  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("res_valid after reset", 32'h0, res_valid);
        check_value("issue_credit after reset", 32'h0, issue_credit);

        test_alu_ops();
        test_operand_select();
        test_store_lanes();
        test_misaligned();
        test_credit_backpressure();
        test_latency();

        repeat (5) @(negedge clk);
        $display("Checks: %0d  errors: %0d  results: %0d", check_count, error_count,
                 results_seen);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+bench
verilog/exu_pkg.sv
verilog/dec_pkg.sv
verilog/exu_ifs.sv
verilog/dispatch_logic.sv
verilog/alu_unit.sv
verilog/agu_unit.sv
verilog/result_merge.sv
verilog/exu_top.sv
bench/exu_tb.sv

//--- verilog/agu_unit.sv
// ============================
// Load/store address, byte mask and store data placement
// ============================
`timescale 1ns/100ps

module agu_unit (
    input  logic    clk_i,
    input  logic    rst_n_i,
    agu_req_if.unit req,
    mem_res_if.unit res
);

    logic [31:0]                addr;
    logic [1:0]                 lane;
    logic [exu_pkg::MASK_W-1:0] lane_mask;
    logic [31:0]                placed;
    logic                       misaligned;
    logic                       is_store;
    logic                       valid_q;
    logic [31:0]                addr_q;
    logic [exu_pkg::MASK_W-1:0] wmask_q;
    logic [31:0]                wdata_q;
    logic                       store_q;
    logic                       misaligned_q;

    assign addr     = req.base + req.offset;
    assign lane     = addr[1:0];
    assign is_store = req.fields.is_store;

    always_comb begin
        case (req.fields.size)
            exu_pkg::SZ_BYTE: begin
                lane_mask = exu_pkg::MASK_W'(1) << lane;
                placed    = {24'b0, req.wdata[7:0]} << {lane, 3'b000};
            end
            exu_pkg::SZ_HALF: begin
                lane_mask = lane[1] ? 4'b1100 : 4'b0011;
                placed    = lane[1] ? {req.wdata[15:0], 16'b0} : {16'b0, req.wdata[15:0]};
            end
            default: begin  // Word
                lane_mask = '1;
                placed    = req.wdata;
            end
        endcase
    end

    assign misaligned = ((req.fields.size == exu_pkg::SZ_WORD) && (lane != 2'b00)) ||
                        ((req.fields.size == exu_pkg::SZ_HALF) && lane[0]);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req.valid) begin
            addr_q       <= addr;
            wmask_q      <= (is_store && !misaligned) ? lane_mask : '0;  // No write if misaligned
            wdata_q      <= is_store ? placed : 32'h0;
            store_q      <= is_store;
            misaligned_q <= misaligned;
        end
    end

    assign res.valid      = valid_q;
    assign res.addr       = addr_q;
    assign res.wmask      = wmask_q;
    assign res.wdata      = wdata_q;
    assign res.is_store   = store_q;
    assign res.misaligned = misaligned_q;

endmodule

//--- verilog/alu_unit.sv
// ============================
// Single-cycle RV32I integer ALU
// ============================
`timescale 1ns/100ps

module alu_unit (
    input  logic        clk_i,
    input  logic        rst_n_i,
    alu_req_if.unit     req,
    output logic        alu_valid_o,
    output logic [31:0] alu_result_o
);

    logic [31:0] result;
    logic [4:0]  shamt;
    logic        valid_q;
    logic [31:0] result_q;

    assign shamt = req.op2[4:0];  // RV32 uses 5 shift bits

    always_comb begin
        case (req.op)
            dec_pkg::ADD:  result = req.op1 + req.op2;
            dec_pkg::SUB:  result = req.op1 - req.op2;
            dec_pkg::SLL:  result = req.op1 << shamt;
            dec_pkg::SLT:  result = {31'b0, $signed(req.op1) < $signed(req.op2)};
            dec_pkg::SLTU: result = {31'b0, req.op1 < req.op2};
            dec_pkg::XOR:  result = req.op1 ^ req.op2;
            dec_pkg::SRL:  result = req.op1 >> shamt;
            dec_pkg::SRA:  result = $unsigned($signed(req.op1) >>> shamt);
            dec_pkg::OR:   result = req.op1 | req.op2;
            dec_pkg::AND:  result = req.op1 & req.op2;
            default:       result = 32'h0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
        end
    end

    // Result held until the next request
    always_ff @(posedge clk_i) begin
        if (req.valid) begin
            result_q <= result;
        end
    end

    assign alu_valid_o  = valid_q;
    assign alu_result_o = result_q;

endmodule

//--- verilog/dec_pkg.sv
// ============================
// Decoded instruction types seen by dispatch.
// Info word read per group as ALU or memory fields.
// ============================

package dec_pkg;

    localparam int unsigned INFO_W = 16;

    typedef enum logic [0:0] {
        GRP_ALU = 1'b0,
        GRP_MEM = 1'b1
    } grp_e;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_op_e;

    typedef struct packed {
        alu_op_e             op;
        logic                op1_pc;   // AUIPC
        logic                op1_zero; // LUI
        logic                op2_imm;
        logic [INFO_W-8:0]   pad;
    } alu_fields_t;

    typedef struct packed {
        logic                is_store;
        exu_pkg::size_e      size;
        logic                is_unsigned; // Load extension, kept for writeback
        logic [INFO_W-5:0]   pad;
    } mem_fields_t;

    typedef union packed {
        alu_fields_t alu;
        mem_fields_t mem;
    } dec_info_u;

endpackage

//--- verilog/dispatch_logic.sv
// ============================
// Registers one issued instruction and
// sends it to the ALU or the AGU by group
// ============================
`timescale 1ns/100ps

module dispatch_logic (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               issue_valid_i,
    input  dec_pkg::grp_e      issue_grp_i,
    input  dec_pkg::dec_info_u issue_info_i,
    input  logic [31:0]        issue_pc_i,
    input  logic [31:0]        issue_imm_i,
    input  logic [31:0]        rs1_rdata_i,
    input  logic [31:0]        rs2_rdata_i,
    alu_req_if.disp            alu_req,
    agu_req_if.disp            agu_req
);

    logic                 is_alu;
    logic                 is_mem;
    logic [31:0]          alu_op1;
    logic [31:0]          alu_op2;
    logic                 alu_valid_q;
    logic                 agu_valid_q;
    logic [31:0]          alu_op1_q;
    logic [31:0]          alu_op2_q;
    dec_pkg::alu_op_e     alu_op_q;
    logic [31:0]          base_q;
    logic [31:0]          offset_q;
    logic [31:0]          sdata_q;
    dec_pkg::mem_fields_t mem_fields_q;

    assign is_alu = issue_valid_i && (issue_grp_i == dec_pkg::GRP_ALU);
    assign is_mem = issue_valid_i && (issue_grp_i == dec_pkg::GRP_MEM);

    // Operand 1 is PC for AUIPC, zero for LUI
    always_comb begin
        if (issue_info_i.alu.op1_pc) begin
            alu_op1 = issue_pc_i;
        end else if (issue_info_i.alu.op1_zero) begin
            alu_op1 = 32'h0;
        end else begin
            alu_op1 = rs1_rdata_i;
        end
    end

    assign alu_op2 = issue_info_i.alu.op2_imm ? issue_imm_i : rs2_rdata_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            alu_valid_q <= 1'b0;
            agu_valid_q <= 1'b0;
        end else begin
            alu_valid_q <= is_alu;
            agu_valid_q <= is_mem;
        end
    end

    always_ff @(posedge clk_i) begin
        if (is_alu) begin
            alu_op1_q <= alu_op1;
            alu_op2_q <= alu_op2;
            alu_op_q  <= issue_info_i.alu.op;
        end
        if (is_mem) begin
            base_q       <= rs1_rdata_i;
            offset_q     <= issue_imm_i;
            sdata_q      <= rs2_rdata_i;   // rs2 is store data
            mem_fields_q <= issue_info_i.mem;
        end
    end

    assign alu_req.valid  = alu_valid_q;
    assign alu_req.op1    = alu_op1_q;
    assign alu_req.op2    = alu_op2_q;
    assign alu_req.op     = alu_op_q;

    assign agu_req.valid  = agu_valid_q;
    assign agu_req.base   = base_q;
    assign agu_req.offset = offset_q;
    assign agu_req.wdata  = sdata_q;
    assign agu_req.fields = mem_fields_q;

endmodule

//--- verilog/exu_ifs.sv
// ============================
// Request and result links between dispatch, units and merge
// ============================
`timescale 1ns/100ps

interface alu_req_if;
    logic             valid;
    logic [31:0]      op1;
    logic [31:0]      op2;
    dec_pkg::alu_op_e op;

    modport disp (output valid, op1, op2, op);
    modport unit (input valid, op1, op2, op);
endinterface

interface agu_req_if;
    logic                 valid;
    logic [31:0]          base;
    logic [31:0]          offset;
    logic [31:0]          wdata;  // Store data, unplaced
    dec_pkg::mem_fields_t fields;

    modport disp (output valid, base, offset, wdata, fields);
    modport unit (input valid, base, offset, wdata, fields);
endinterface

interface mem_res_if;
    logic                       valid;
    logic [31:0]                addr;
    logic [exu_pkg::MASK_W-1:0] wmask;
    logic [31:0]                wdata;
    logic                       is_store;
    logic                       misaligned;

    modport unit (
        output valid, addr, wmask, wdata, is_store, misaligned
    );
    modport merge (
        input valid, addr, wmask, wdata, is_store, misaligned
    );
endinterface

//--- verilog/exu_pkg.sv
// ============================
// Execute result types and sizing for the result queue
// ============================

package exu_pkg;

    // Byte lanes of a 32-bit data word
    localparam int unsigned MASK_W = 4;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } size_e;

    // Bits needed to hold a count from 0 up to max_count
    function automatic int unsigned cnt_w(input int unsigned max_count);
        int unsigned w;
        w = $clog2(max_count + 1);
        if (w == 0) begin
            w = 1;
        end
        return w;
    endfunction

endpackage

//--- verilog/exu_top.sv
// ============================
// Dispatch and execute slice, credit flow on both sides
// ============================
`timescale 1ns/100ps

module exu_top #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       issue_valid_i,
    input  dec_pkg::grp_e              issue_grp_i,
    input  dec_pkg::dec_info_u         issue_info_i,
    input  logic [31:0]                issue_pc_i,
    input  logic [31:0]                issue_imm_i,
    input  logic [31:0]                rs1_rdata_i,
    input  logic [31:0]                rs2_rdata_i,
    output logic                       issue_credit_o,
    input  logic                       res_credit_i,
    output logic                       res_valid_o,
    output dec_pkg::grp_e              res_grp_o,
    output logic [31:0]                res_data_o,
    output logic [exu_pkg::MASK_W-1:0] res_wmask_o,
    output logic [31:0]                res_wdata_o,
    output logic                       res_store_o,
    output logic                       res_misaligned_o
);

    logic        alu_valid;
    logic [31:0] alu_result;

    alu_req_if alu_req ();
    agu_req_if agu_req ();
    mem_res_if mem_res ();

    dispatch_logic dispatch_logic_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_grp_i   (issue_grp_i),
        .issue_info_i  (issue_info_i),
        .issue_pc_i    (issue_pc_i),
        .issue_imm_i   (issue_imm_i),
        .rs1_rdata_i   (rs1_rdata_i),
        .rs2_rdata_i   (rs2_rdata_i),
        .alu_req       (alu_req.disp),
        .agu_req       (agu_req.disp)
    );

    alu_unit alu_unit_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req          (alu_req.unit),
        .alu_valid_o  (alu_valid),
        .alu_result_o (alu_result)
    );

    agu_unit agu_unit_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req     (agu_req.unit),
        .res     (mem_res.unit)
    );

    result_merge #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) result_merge_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .alu_valid_i      (alu_valid),
        .alu_result_i     (alu_result),
        .mem_res          (mem_res.merge),
        .res_credit_i     (res_credit_i),
        .res_valid_o      (res_valid_o),
        .res_grp_o        (res_grp_o),
        .res_data_o       (res_data_o),
        .res_wmask_o      (res_wmask_o),
        .res_wdata_o      (res_wdata_o),
        .res_store_o      (res_store_o),
        .res_misaligned_o (res_misaligned_o),
        .issue_credit_o   (issue_credit_o)
    );

endmodule

//--- verilog/result_merge.sv
// ============================
// In-order result queue fed by both units.
// Output credits gate pops, each pop returns an issue credit.
// ============================
`timescale 1ns/100ps

module result_merge #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       alu_valid_i,
    input  logic [31:0]                alu_result_i,
    mem_res_if.merge                   mem_res,
    input  logic                       res_credit_i,
    output logic                       res_valid_o,
    output dec_pkg::grp_e              res_grp_o,
    output logic [31:0]                res_data_o,
    output logic [exu_pkg::MASK_W-1:0] res_wmask_o,
    output logic [31:0]                res_wdata_o,
    output logic                       res_store_o,
    output logic                       res_misaligned_o,
    output logic                       issue_credit_o
);

    // grp, data, wmask, wdata, store, misaligned
    localparam int unsigned ENTRY_W = 1 + 32 + exu_pkg::MASK_W + 32 + 1 + 1;
    localparam int unsigned PTR_W   = $clog2(FIFO_DEPTH);
    localparam int unsigned CNT_W   = exu_pkg::cnt_w(FIFO_DEPTH);
    localparam int unsigned CRED_W  = exu_pkg::cnt_w(16 * FIFO_DEPTH); // Consumer may run ahead

    logic [ENTRY_W-1:0] queue_mem [FIFO_DEPTH];
    logic [ENTRY_W-1:0] push_entry;
    logic [ENTRY_W-1:0] head;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   q_count;
    logic [CRED_W-1:0]  out_cred;
    logic               push;
    logic               pop;
    dec_pkg::grp_e      push_grp;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Units never finish in the same cycle, one issue per cycle
    assign push     = alu_valid_i | mem_res.valid;
    assign push_grp = mem_res.valid ? dec_pkg::GRP_MEM : dec_pkg::GRP_ALU;

    assign push_entry = mem_res.valid ?
        {push_grp, mem_res.addr, mem_res.wmask, mem_res.wdata,
         mem_res.is_store, mem_res.misaligned} :
        {push_grp, alu_result_i, exu_pkg::MASK_W'(0), 32'h0, 1'b0, 1'b0};

    assign pop = (q_count != '0) && (out_cred != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            q_count  <= '0;
            out_cred <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            q_count  <= q_count + CNT_W'(push) - CNT_W'(pop);
            out_cred <= out_cred + CRED_W'(res_credit_i) - CRED_W'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            queue_mem[wr_ptr] <= push_entry;
        end
    end

    assign head = queue_mem[rd_ptr];

    assign res_valid_o    = pop;
    assign issue_credit_o = pop;  // Slot freed
    assign res_grp_o      = dec_pkg::grp_e'(head[ENTRY_W-1]);
    assign {res_data_o, res_wmask_o, res_wdata_o, res_store_o, res_misaligned_o} =
        head[ENTRY_W-2:0];

endmodule
